/* files.f */
source/cropPkg.sv
source/cropIfs.sv
source/scanTracker.sv
source/cellAccumulator.sv
source/cellGrid.sv
source/wbGridSlave.sv
source/cropDownMean.sv
testbench/cropTb_chk.sv
testbench/cropTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cropTb -f files.f \
  && ./obj_dir/VcropTb +verilator+error+limit+100 | tee /dev/stderr \
  | grep -qF "ALL TESTS PASSED" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

/* testbench/cropTb.sv */
`timescale 1ns/10ps
module cropTb;
  import cropPkg::*;

  logic iCLK = 1'b0;
  logic iRST;
  logic pixValid;
  logic [colW-1:0] pixLine;
  logic [pixW-1:0] pixGray;
  logic frameStart;
  logic wbCyc;
  logic wbStb;
  logic wbWe;
  logic [addrW-1:0] wbAdr;
  logic [dataW-1:0] wbDatI;
  logic [dataW-1:0] wbDatO;
  logic wbAck;

  int errors;
  logic [dataW-1:0] word;

  cropDownMean DUT (
    .iCLK       (iCLK),
    .iRST       (iRST),
    .pixValid   (pixValid),
    .pixLine    (pixLine),
    .pixGray    (pixGray),
    .frameStart (frameStart),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbWe       (wbWe),
    .wbAdr      (wbAdr),
    .wbDatI     (wbDatI),
    .wbDatO     (wbDatO),
    .wbAck      (wbAck)
  );

  // 8 ns period
  always #4 iCLK = ~iCLK;

  // stimulus value of one cell
  function automatic int cellValue(input int row, input int col);
    return (row * 37 + col * 11 + 100) % 4096;
  endfunction

  // 336 equal pixels summed, then divided by 512
  function automatic int cellLevel(input int row, input int col);
    return (cellValue(row, col) * 336) / 512;
  endfunction

  // window pixels carry their cell value, the rest is noise
  function automatic logic [pixW-1:0] pixelAt(input int col, input int line);
    logic [pixW-1:0] px;
    if (col >= cropX0 && col <= cropX1 && line >= cropY0 && line <= cropY1) begin
      px = pixW'(cellValue((line - cropY0) / cellH, (col - cropX0) / cellW));
    end else begin
      px = pixW'($urandom);
    end
    return px;
  endfunction

  // one clock, inputs move 1 ns after the edge
  task automatic tick();
    @(posedge iCLK);
    #1;
  endtask

  task automatic sendLine(input int line);
    int col;
    col = 1;
    pixLine = colW'(line);
    while (col <= lineWidth) begin
      // roughly one cycle in eight is a gap
      if ($urandom_range(7) == 0) begin
        pixValid = 1'b0;
        pixGray = pixW'($urandom);
      end else begin
        pixValid = 1'b1;
        pixGray = pixelAt(col, line);
        col++;
      end
      tick();
    end
    pixValid = 1'b0;
    // blanking between lines
    repeat (20) tick();
  endtask

  task automatic sendFrame(input int lines);
    frameStart = 1'b1;
    tick();
    frameStart = 1'b0;
    for (int y = 0; y < lines; y++) begin
      sendLine(y);
    end
  endtask

  // classic cycle, held until ack or timeout
  task automatic wbAccess(input logic we, input int adr, input logic [dataW-1:0] wdata,
                          output logic [dataW-1:0] rdata);
    int waited;
    waited = 0;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = we;
    wbAdr = addrW'(adr);
    wbDatI = wdata;
    tick();
    while (!wbAck && waited < 10) begin
      tick();
      waited++;
    end
    if (!wbAck) begin
      $display("%0t: no Wishbone ack for address %0d", $time, adr);
      errors++;
    end
    rdata = wbDatO;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    tick();
  endtask

  task automatic expectWord(input string name, input int exp, input logic [dataW-1:0] act);
    assert (act == dataW'(exp)) else begin
      $display("CHECK FAILED %0t %s expected %0d actual %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  // every cell against its scaled mean
  task automatic checkGrid();
    logic [dataW-1:0] got;
    for (int r = 0; r < gridN; r++) begin
      for (int c = 0; c < gridN; c++) begin
        wbAccess(1'b0, r * gridN + c, '0, got);
        expectWord($sformatf("wbDatO cell %0d,%0d", r, c), cellLevel(r, c), got);
      end
    end
  endtask

  // poll the status word until frame ready
  task automatic waitReady();
    int polls;
    logic [dataW-1:0] st;
    polls = 0;
    wbAccess(1'b0, statusAddr, '0, st);
    while (!st[0] && polls < 100) begin
      wbAccess(1'b0, statusAddr, '0, st);
      polls++;
    end
    if (!st[0]) begin
      $display("%0t: frame ready flag never came up", $time);
      errors++;
    end
  endtask

  initial begin
    void'($urandom(32'h07d5_47e3));
    errors = 0;
    iRST = 1'b0;
    pixValid = 1'b0;
    pixLine = '0;
    pixGray = '0;
    frameStart = 1'b0;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatI = '0;
    repeat (10) @(posedge iCLK);
    #1;
    iRST = 1'b1;
    tick();

    // nothing stored yet
    wbAccess(1'b0, statusAddr, '0, word);
    expectWord("wbDatO status", 0, word);

    sendFrame(480);
    waitReady();
    // ready in bit 0, last row 27 in bits 5:1
    wbAccess(1'b0, statusAddr, '0, word);
    expectWord("wbDatO status", ((gridN - 1) << 1) | 1, word);
    checkGrid();

    // past the status word
    wbAccess(1'b0, statusAddr + 1, '0, word);
    expectWord("wbDatO addr 785", 0, word);
    wbAccess(1'b0, 1023, '0, word);
    expectWord("wbDatO addr 1023", 0, word);

    // write is acked, cell 3,16 keeps its level
    wbAccess(1'b1, 3 * gridN + 16, 16'hffff, word);
    wbAccess(1'b0, 3 * gridN + 16, '0, word);
    expectWord("wbDatO cell 3,16", cellLevel(3, 16), word);

    // partial frame, flag drops and grid survives
    sendFrame(20);
    wbAccess(1'b0, statusAddr, '0, word);
    expectWord("wbDatO status", 0, word);
    checkGrid();

    sendFrame(480);
    waitReady();
    wbAccess(1'b0, statusAddr, '0, word);
    expectWord("wbDatO status", ((gridN - 1) << 1) | 1, word);

    $display("%0d check errors, %0d protocol assertion failures",
             errors, DUT.protoChk.fails);
    if (errors == 0 && DUT.protoChk.fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* testbench/cropTb_chk.sv */
`timescale 1ns/10ps
module protocolChecks (
  input logic iCLK,
  input logic iRST,
  input logic wbCyc,
  input logic wbStb,
  input logic wbAck,
  input logic cellValid
);

  int fails = 0;

  // length of the current run of cellBus valid
  logic [5:0] runLen;

  always_ff @(posedge iCLK or negedge iRST) begin
    if (!iRST) begin
      runLen <= '0;
    end else if (cellValid) begin
      runLen <= runLen + 6'd1;
    end else begin
      runLen <= '0;
    end
  end

  // single cycle ack
  ackOnePulse: assert property (@(posedge iCLK) disable iff (!iRST)
    wbAck |=> !wbAck)
    else begin
      $error("wishbone ack held for more than one cycle");
      fails++;
    end

  // ack needs a request in the cycle before
  ackAfterRequest: assert property (@(posedge iCLK) disable iff (!iRST)
    wbAck |-> $past(wbCyc && wbStb))
    else begin
      $error("wishbone ack without cyc and stb");
      fails++;
    end

  // a drain never runs past one band
  burstNotLong: assert property (@(posedge iCLK) disable iff (!iRST)
    cellValid |-> runLen < 6'd28)
    else begin
      $error("cellBus valid burst longer than 28");
      fails++;
    end

  // and never stops short of it
  burstFull: assert property (@(posedge iCLK) disable iff (!iRST)
    $fell(cellValid) |-> runLen == 6'd28)
    else begin
      $error("cellBus valid burst shorter than 28");
      fails++;
    end

endmodule

bind cropDownMean protocolChecks protoChk (
  .iCLK      (iCLK),
  .iRST      (iRST),
  .wbCyc     (wbCyc),
  .wbStb     (wbStb),
  .wbAck     (wbAck),
  .cellValid (cellLink.valid)
);

/* source/cropDownMean.sv */
`timescale 1ns/10ps
module cropDownMean (
  input  logic iCLK,
  input  logic iRST,
  // camera stream
  input  logic pixValid,
  input  logic [cropPkg::colW-1:0] pixLine,
  input  logic [cropPkg::pixW-1:0] pixGray,
  input  logic frameStart,
  // wishbone slave
  input  logic wbCyc,
  input  logic wbStb,
  input  logic wbWe,
  input  logic [cropPkg::addrW-1:0] wbAdr,
  input  logic [cropPkg::dataW-1:0] wbDatI,
  output logic [cropPkg::dataW-1:0] wbDatO,
  output logic wbAck
);

  // tracker to accumulator, one stage behind the input
  logic pixValidQ;
  logic [cropPkg::pixW-1:0] pixGrayQ;
  logic inWindow;
  logic [cropPkg::idxW-1:0] cellCol;
  logic bandClose;
  logic [cropPkg::idxW-1:0] bandRow;

  cellBus cellLink ();
  gridPort gridLink ();

  scanTracker tracker (
    .iCLK       (iCLK),
    .iRST       (iRST),
    .frameStart (frameStart),
    .pixValid   (pixValid),
    .pixLine    (pixLine),
    .pixGray    (pixGray),
    .pixValidQ  (pixValidQ),
    .pixGrayQ   (pixGrayQ),
    .inWindow   (inWindow),
    .cellCol    (cellCol),
    .bandClose  (bandClose),
    .bandRow    (bandRow)
  );

  cellAccumulator accum (
    .iCLK       (iCLK),
    .iRST       (iRST),
    .frameStart (frameStart),
    .pixValidQ  (pixValidQ),
    .pixGrayQ   (pixGrayQ),
    .inWindow   (inWindow),
    .cellCol    (cellCol),
    .bandClose  (bandClose),
    .bandRow    (bandRow),
    .cells      (cellLink.source)
  );

  cellGrid grid (
    .iCLK       (iCLK),
    .iRST       (iRST),
    .frameStart (frameStart),
    .cells      (cellLink.sink),
    .port       (gridLink.store)
  );

  wbGridSlave wbSlave (
    .iCLK   (iCLK),
    .iRST   (iRST),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatI (wbDatI),
    .wbDatO (wbDatO),
    .wbAck  (wbAck),
    .grid   (gridLink.reader)
  );

endmodule

/* source/wbGridSlave.sv */
`timescale 1ns/10ps
module wbGridSlave (
  input  logic iCLK,
  input  logic iRST,
  input  logic wbCyc,
  input  logic wbStb,
  input  logic wbWe,
  input  logic [cropPkg::addrW-1:0] wbAdr,
  input  logic [cropPkg::dataW-1:0] wbDatI,
  output logic [cropPkg::dataW-1:0] wbDatO,
  output logic wbAck,
  gridPort.reader grid
);
  import cropPkg::*;

  typedef enum logic {
    stIdle,
    stRead
  } slaveState;

  slaveState state;
  logic req;
  logic [dataW-1:0] rdWord;

  assign req = wbCyc && wbStb;

  // address held by the master, grid answers next cycle
  assign grid.rdAddr = wbAdr;

  // word select once rdData has settled
  // writes return zero and change nothing
  always_comb begin
    if (wbWe) begin
      rdWord = '0;
    end else if (wbAdr < addrW'(cellCount)) begin
      rdWord = dataW'(grid.rdData);
    end else if (wbAdr == addrW'(statusAddr)) begin
      rdWord = dataW'({grid.lastRow, grid.frameReady});
    end else begin
      rdWord = '0;
    end
  end

  // idle -> read -> ack, ack lasts one cycle
  always_ff @(posedge iCLK or negedge iRST) begin
    if (!iRST) begin
      state <= stIdle;
      wbAck <= 1'b0;
    end else begin
      wbAck <= 1'b0;
      case (state)
        stIdle: begin
          // ignore the request still held during our own ack
          if (req && !wbAck) begin
            state <= stRead;
          end
        end
        stRead: begin
          // no ack if the master gave up
          wbAck <= req;
          state <= stIdle;
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge iCLK) begin
    if (state == stRead) begin
      wbDatO <= rdWord;
    end
  end

endmodule

/* source/cellGrid.sv */
`timescale 1ns/10ps
module cellGrid (
  input  logic iCLK,
  input  logic iRST,
  input  logic frameStart,
  cellBus.sink cells,
  gridPort.store port
);
  import cropPkg::*;

  // row-major level store
  logic [pixW-1:0] mem [cellCount];
  logic [addrW-1:0] wrPtr;
  logic lastCell;

  // row times 28 plus col
  assign wrPtr = addrW'(cells.row) * addrW'(gridN) + addrW'(cells.col);

  // bottom right cell closes the frame
  assign lastCell = cells.valid &&
                    (cells.row == idxW'(gridN - 1)) &&
                    (cells.col == idxW'(gridN - 1));

  always_ff @(posedge iCLK) begin
    if (cells.valid) begin
      mem[wrPtr] <= cells.level;
    end
  end

  // registered read
  // addresses past the grid give zero
  always_ff @(posedge iCLK) begin
    if (port.rdAddr < addrW'(cellCount)) begin
      port.rdData <= mem[port.rdAddr];
    end else begin
      port.rdData <= '0;
    end
  end

  // status flags, grid contents survive frame start
  always_ff @(posedge iCLK or negedge iRST) begin
    if (!iRST) begin
      port.frameReady <= 1'b0;
      port.lastRow <= '0;
    end else if (frameStart) begin
      port.frameReady <= 1'b0;
      port.lastRow <= '0;
    end else if (cells.valid) begin
      port.lastRow <= cells.row;
      // rises the cycle after the final write
      if (lastCell) begin
        port.frameReady <= 1'b1;
      end
    end
  end

endmodule

/* source/cellAccumulator.sv */
`timescale 1ns/10ps
module cellAccumulator (
  input  logic iCLK,
  input  logic iRST,
  input  logic frameStart,
  input  logic pixValidQ,
  input  logic [cropPkg::pixW-1:0] pixGrayQ,
  input  logic inWindow,
  input  logic [cropPkg::idxW-1:0] cellCol,
  input  logic bandClose,
  input  logic [cropPkg::idxW-1:0] bandRow,
  cellBus.source cells
);
  import cropPkg::*;

  // running sums of the band in progress, one per cell column
  logic [gridN-1:0][sumW-1:0] sums;
  logic [gridN-1:0][sumW-1:0] sumNext;
  // levels of the band just closed, waiting to drain
  logic [gridN-1:0][pixW-1:0] bank;
  logic addHit;
  logic takeBand;
  logic draining;
  logic [idxW-1:0] drainCnt;
  logic [idxW-1:0] drainRow;

  assign addHit = pixValidQ && inWindow;
  assign takeBand = pixValidQ && bandClose;

  // sums with the current pixel folded in
  // the bank copy needs this so the closing pixel counts
  always_comb begin
    for (int i = 0; i < gridN; i++) begin
      sumNext[i] = sums[i];
      if (addHit && (cellCol == idxW'(i))) begin
        sumNext[i] = sums[i] + sumW'(pixGrayQ);
      end
    end
  end

  always_ff @(posedge iCLK or negedge iRST) begin
    if (!iRST) begin
      sums <= '0;
    end else if (frameStart || takeBand) begin
      // next band starts from zero
      sums <= '0;
    end else begin
      sums <= sumNext;
    end
  end

  // scaled mean, sum over 512
  always_ff @(posedge iCLK) begin
    if (takeBand) begin
      for (int i = 0; i < gridN; i++) begin
        bank[i] <= sumNext[i][sumW-1 -: pixW];
      end
    end
  end

  // drain walks the bank from column 0, one cell per cycle
  always_ff @(posedge iCLK or negedge iRST) begin
    if (!iRST) begin
      draining <= 1'b0;
      drainCnt <= '0;
      drainRow <= '0;
    end else if (frameStart) begin
      draining <= 1'b0;
      drainCnt <= '0;
      drainRow <= '0;
    end else if (takeBand) begin
      draining <= 1'b1;
      drainCnt <= '0;
      drainRow <= bandRow;
    end else if (draining) begin
      if (drainCnt == idxW'(gridN - 1)) begin
        draining <= 1'b0;
        drainCnt <= '0;
      end else begin
        drainCnt <= drainCnt + idxW'(1);
      end
    end
  end

  assign cells.valid = draining;
  assign cells.row = drainRow;
  assign cells.col = drainCnt;
  assign cells.level = bank[drainCnt];

endmodule

/* source/scanTracker.sv */
`timescale 1ns/10ps
module scanTracker (
  input  logic iCLK,
  input  logic iRST,
  input  logic frameStart,
  input  logic pixValid,
  input  logic [cropPkg::colW-1:0] pixLine,
  input  logic [cropPkg::pixW-1:0] pixGray,
  output logic pixValidQ,
  output logic [cropPkg::pixW-1:0] pixGrayQ,
  output logic inWindow,
  output logic [cropPkg::idxW-1:0] cellCol,
  output logic bandClose,
  output logic [cropPkg::idxW-1:0] bandRow
);
  import cropPkg::*;

  // column of the last accepted pixel, 0 right after frame start
  logic [colW-1:0] colCnt;
  logic [colW-1:0] curCol;
  logic [colW-1:0] lineOff;
  // pixel position inside the current cell
  logic [idxW-1:0] subCnt;
  logic [idxW-1:0] subNext;
  logic [idxW-1:0] cellNext;
  logic colHit;
  logic lineHit;
  logic closeHit;

  always_comb begin
    // column of the pixel on the input now, 1 to 640
    curCol = (colCnt == colW'(lineWidth)) ? colW'(1) : colCnt + colW'(1);
    lineOff = pixLine - colW'(cropY0);
    colHit = (curCol >= colW'(cropX0)) && (curCol <= colW'(cropX1));
    lineHit = (pixLine >= colW'(cropY0)) && (pixLine <= colW'(cropY1));
    // last pixel of the bottom line of a band
    closeHit = colHit && lineHit && (curCol == colW'(cropX1)) &&
               ((lineOff % cellH) == cellH - 1);
    // cell column steps every cellW pixels from the window edge
    if (curCol == colW'(cropX0)) begin
      cellNext = '0;
      subNext = '0;
    end else if (subCnt == idxW'(cellW - 1)) begin
      cellNext = cellCol + idxW'(1);
      subNext = '0;
    end else begin
      cellNext = cellCol;
      subNext = subCnt + idxW'(1);
    end
  end

  always_ff @(posedge iCLK or negedge iRST) begin
    if (!iRST) begin
      colCnt <= '0;
      subCnt <= '0;
      cellCol <= '0;
      bandRow <= '0;
      pixValidQ <= 1'b0;
      inWindow <= 1'b0;
      bandClose <= 1'b0;
    end else if (frameStart) begin
      colCnt <= '0;
      subCnt <= '0;
      cellCol <= '0;
      bandRow <= '0;
      pixValidQ <= 1'b0;
      inWindow <= 1'b0;
      bandClose <= 1'b0;
    end else begin
      pixValidQ <= pixValid;
      // flags only qualify a valid pixel
      inWindow <= pixValid && colHit && lineHit;
      bandClose <= pixValid && closeHit;
      if (pixValid) begin
        colCnt <= curCol;
        subCnt <= subNext;
        cellCol <= cellNext;
        bandRow <= idxW'(lineOff / cellH);
      end
    end
  end

  // pixel data rides along with its flags
  always_ff @(posedge iCLK) begin
    if (pixValid) begin
      pixGrayQ <= pixGray;
    end
  end

endmodule

/* source/cropIfs.sv */
`timescale 1ns/10ps

// one finished cell level per cycle, no back-pressure
interface cellBus;
  import cropPkg::*;

  logic valid;
  logic [idxW-1:0] row;
  logic [idxW-1:0] col;
  logic [pixW-1:0] level;

  // accumulator side
  modport source (output valid, row, col, level);
  // grid store side
  modport sink (input valid, row, col, level);
endinterface

// read path from the bus slave into the grid
interface gridPort;
  import cropPkg::*;

  logic [addrW-1:0] rdAddr;
  // registered, one cycle after rdAddr
  logic [pixW-1:0] rdData;
  logic frameReady;
  logic [idxW-1:0] lastRow;

  // grid side
  modport store (input rdAddr, output rdData, frameReady, lastRow);
  // wishbone side
  modport reader (output rdAddr, input rdData, frameReady, lastRow);
endinterface

/* source/cropPkg.sv */
package cropPkg;

  // incoming frame geometry
  localparam int lineWidth = 640;

  // crop window, bounds inclusive
  // columns count from 1, lines from 0
  localparam int cropX0 = 27;
  localparam int cropX1 = 614;
  localparam int cropY0 = 17;
  localparam int cropY1 = 464;

  // one cell of the reduced grid
  localparam int cellW = 21;
  localparam int cellH = 16;

  // grid is square
  localparam int gridN = 28;
  localparam int cellCount = gridN * gridN;

  // gray pixel and cell level share a width
  localparam int pixW = 12;

  // 336 pixels of 12 bits fit in 21 bits
  localparam int sumW = 21;

  // column and line counters
  localparam int colW = 10;

  // cell row or column index
  localparam int idxW = 5;

  // grid word address, also the wishbone word address
  localparam int addrW = 10;

  // wishbone data bus
  localparam int dataW = 16;

  // status word sits right after the last cell
  localparam int statusAddr = cellCount;

endpackage
